// ==== lrelu_pkg.sv ====
`default_nettype none

package lrelu_pkg;

  // sample and coefficient widths
  localparam int WORD_IN_W  = 16;
  localparam int WORD_OUT_W = 8;
  localparam int COEF_W     = 16;
  // coefficients are Q8.8
  localparam int COEF_FRAC  = 8;

  // user field bit positions
  localparam int USER_W     = 2;
  localparam int I_IS_LRELU = 0;
  localparam int I_IS_1X1   = 1;

  // output saturation bounds
  localparam int OUT_MAX = 127;
  localparam int OUT_MIN = -128;

  // enabled cycles from s_valid to m_valid
  localparam int PIPE_LATENCY = 4;

  typedef logic signed [WORD_IN_W-1:0]  word_in_t;
  typedef logic signed [WORD_OUT_W-1:0] word_out_t;
  typedef logic signed [COEF_W-1:0]     coef_t;
  typedef logic        [USER_W-1:0]     user_t;

  // index width covering the 1x1 memory depth
  function automatic int idx_width(input int members);
    return $clog2(3 * members);
  endfunction

endpackage

`default_nettype wire

// ==== beat_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface beat_if #(
  parameter int GROUPS  = 2,
  parameter int UNITS   = 4,
  parameter int MEMBERS = 2
);
  import lrelu_pkg::*;

  logic     valid;
  user_t    user;
  word_in_t data [GROUPS][UNITS];
  // coefficient address for the beat being registered
  logic [idx_width(MEMBERS)-1:0] rd_idx;

  modport stage (output valid, output user, output data, output rd_idx);

  modport store (input rd_idx);

  modport unit (input valid, input user, input data);

endinterface

`default_nettype wire

// ==== sample_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module sample_stage #(
  parameter int GROUPS  = 2,
  parameter int UNITS   = 4,
  parameter int MEMBERS = 2
) (
  input  logic                 clk,
  input  logic                 clken,
  input  logic                 rst_n,
  input  logic                 cfg_clear,
  input  logic                 s_valid,
  input  lrelu_pkg::user_t     s_user,
  input  lrelu_pkg::word_in_t  s_data [GROUPS][UNITS],
  beat_if.stage                beat
);
  import lrelu_pkg::*;

  localparam int IDX_W = idx_width(MEMBERS);

  logic [IDX_W-1:0] rd_cnt;
  logic [IDX_W-1:0] last_idx;

  // wrap point follows the depth of the incoming beat
  assign last_idx = s_user[I_IS_1X1] ? IDX_W'(3 * MEMBERS - 1) : IDX_W'(MEMBERS - 1);
  assign beat.rd_idx = rd_cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beat.valid <= 1'b0;
      rd_cnt     <= '0;
    end else if (clken) begin
      beat.valid <= s_valid;
      if (cfg_clear) begin
        rd_cnt <= '0;
      end else if (s_valid) begin
        rd_cnt <= (rd_cnt >= last_idx) ? '0 : rd_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (clken) begin
      beat.user <= s_user;
      beat.data <= s_data;
    end
  end

endmodule

`default_nettype wire

// ==== coef_store.sv ====
`timescale 1ns/10ps
`default_nettype none

module coef_store #(
  parameter int GROUPS  = 2,
  parameter int MEMBERS = 2
) (
  input  logic             clk,
  input  logic             clken,
  input  logic             rst_n,
  input  logic             cfg_clear,
  input  logic             cfg_valid,
  input  logic             cfg_is_1x1,
  input  lrelu_pkg::coef_t cfg_data [GROUPS],
  beat_if.store            beat,
  output lrelu_pkg::coef_t a_val [GROUPS],
  output lrelu_pkg::coef_t b_val [GROUPS],
  output lrelu_pkg::coef_t d_val [GROUPS]
);
  import lrelu_pkg::*;

  localparam int DEPTH = 3 * MEMBERS;
  localparam int IDX_W = idx_width(MEMBERS);

  // write order is D, then A, then B, then D again
  typedef enum logic [1:0] {
    SEL_D,
    SEL_A,
    SEL_B
  } sel_t;

  sel_t             sel;
  logic [IDX_W-1:0] waddr;
  logic [IDX_W-1:0] last_addr;
  logic             wr_d;
  logic             wr_a;
  logic             wr_b;

  coef_t a_mem [GROUPS][DEPTH];
  coef_t b_mem [GROUPS][DEPTH];
  coef_t d_reg [GROUPS];

  assign last_addr = cfg_is_1x1 ? IDX_W'(DEPTH - 1) : IDX_W'(MEMBERS - 1);

  assign wr_d = cfg_valid && !cfg_clear && (sel == SEL_D);
  assign wr_a = cfg_valid && !cfg_clear && (sel == SEL_A);
  assign wr_b = cfg_valid && !cfg_clear && (sel == SEL_B);

  // write sequencer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sel   <= SEL_D;
      waddr <= '0;
    end else if (clken) begin
      if (cfg_clear) begin
        sel   <= SEL_D;
        waddr <= '0;
      end else if (cfg_valid) begin
        unique case (sel)
          SEL_D: begin
            sel   <= SEL_A;
            waddr <= '0;
          end
          SEL_A: begin
            if (waddr >= last_addr) begin
              sel   <= SEL_B;
              waddr <= '0;
            end else begin
              waddr <= waddr + 1'b1;
            end
          end
          SEL_B: begin
            if (waddr >= last_addr) begin
              sel   <= SEL_D;
              waddr <= '0;
            end else begin
              waddr <= waddr + 1'b1;
            end
          end
          default: sel <= SEL_D;
        endcase
      end
    end
  end

  // old word is read when write and read hit the same cycle
  always_ff @(posedge clk) begin
    if (clken) begin
      for (int g = 0; g < GROUPS; g++) begin
        if (wr_d) d_reg[g] <= cfg_data[g];
        if (wr_a) a_mem[g][waddr] <= cfg_data[g];
        if (wr_b) b_mem[g][waddr] <= cfg_data[g];
        a_val[g] <= a_mem[g][beat.rd_idx];
        b_val[g] <= b_mem[g][beat.rd_idx];
        d_val[g] <= d_reg[g];
      end
    end
  end

endmodule

`default_nettype wire

// ==== unit_array.sv ====
`timescale 1ns/10ps
`default_nettype none

module unit_array #(
  parameter int GROUPS      = 2,
  parameter int UNITS       = 4,
  parameter int LRELU_ALPHA = 26
) (
  input  logic                 clk,
  input  logic                 clken,
  input  logic                 rst_n,
  beat_if.unit                 beat,
  input  lrelu_pkg::coef_t     a_val [GROUPS],
  input  lrelu_pkg::coef_t     b_val [GROUPS],
  input  lrelu_pkg::coef_t     d_val [GROUPS],
  output logic                 m_valid,
  output lrelu_pkg::user_t     m_user,
  output lrelu_pkg::word_out_t m_data [GROUPS][UNITS]
);
  import lrelu_pkg::*;

  localparam int PROD_W     = WORD_IN_W + COEF_W;
  // alpha is Q0.8
  localparam int ALPHA_FRAC = 8;

  typedef logic signed [PROD_W-1:0]    prod_t;
  typedef logic signed [PROD_W+9:0]    wide_t;

  logic  v1, v2;
  user_t u1, u2;
  prod_t p1 [GROUPS][UNITS];
  prod_t s2 [GROUPS][UNITS];
  coef_t b1 [GROUPS];
  coef_t d1 [GROUPS];
  coef_t d2 [GROUPS];

  // negative sums scaled by alpha when enabled
  function automatic prod_t leaky(input prod_t v, input logic en);
    wide_t scaled;
    scaled = (wide_t'(v) * wide_t'(LRELU_ALPHA)) >>> ALPHA_FRAC;
    if (en && (v < 0)) return prod_t'(scaled);
    return v;
  endfunction

  function automatic word_out_t saturate(input prod_t v);
    if (v > prod_t'(OUT_MAX)) return word_out_t'(OUT_MAX);
    if (v < prod_t'(OUT_MIN)) return word_out_t'(OUT_MIN);
    return word_out_t'(v);
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      v1      <= 1'b0;
      v2      <= 1'b0;
      m_valid <= 1'b0;
    end else if (clken) begin
      v1      <= beat.valid;
      v2      <= v1;
      m_valid <= v2;
    end
  end

  // stage 1 product, stage 2 bias and leaky relu, stage 3 offset and clamp
  always_ff @(posedge clk) begin
    if (clken) begin
      u1     <= beat.user;
      u2     <= u1;
      m_user <= u2;
      for (int g = 0; g < GROUPS; g++) begin
        b1[g] <= b_val[g];
        d1[g] <= d_val[g];
        d2[g] <= d1[g];
        for (int u = 0; u < UNITS; u++) begin
          p1[g][u]     <= (prod_t'(beat.data[g][u]) * prod_t'(a_val[g])) >>> COEF_FRAC;
          s2[g][u]     <= leaky(p1[g][u] + prod_t'(b1[g]), u1[I_IS_LRELU]);
          m_data[g][u] <= saturate(s2[g][u] + prod_t'(d2[g]));
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== lrelu_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module lrelu_engine #(
  parameter int GROUPS      = 2,
  parameter int UNITS       = 4,
  parameter int MEMBERS     = 2,
  parameter int LRELU_ALPHA = 26
) (
  input  logic                                             clk,
  input  logic                                             clken,
  input  logic                                             rst_n,
  input  logic                                             s_valid,
  input  lrelu_pkg::user_t                                 s_user,
  input  logic [GROUPS*UNITS*lrelu_pkg::WORD_IN_W-1:0]     s_data,
  input  logic                                             cfg_clear,
  input  logic                                             cfg_valid,
  input  logic                                             cfg_is_1x1,
  input  logic [GROUPS*lrelu_pkg::COEF_W-1:0]              cfg_data,
  output logic                                             m_valid,
  output lrelu_pkg::user_t                                 m_user,
  output logic [GROUPS*UNITS*lrelu_pkg::WORD_OUT_W-1:0]    m_data
);
  import lrelu_pkg::*;

  word_in_t  s_data_gu [GROUPS][UNITS];
  word_out_t m_data_gu [GROUPS][UNITS];
  coef_t     cfg_data_g [GROUPS];
  coef_t     a_val [GROUPS];
  coef_t     b_val [GROUPS];
  coef_t     d_val [GROUPS];

  // flat buses hold group g unit u at slot g*UNITS+u, slot 0 in the lsbs
  for (genvar g = 0; g < GROUPS; g++) begin : g_flat
    assign cfg_data_g[g] = cfg_data[g*COEF_W +: COEF_W];
    for (genvar u = 0; u < UNITS; u++) begin : u_flat
      assign s_data_gu[g][u] = s_data[(g*UNITS+u)*WORD_IN_W +: WORD_IN_W];
      assign m_data[(g*UNITS+u)*WORD_OUT_W +: WORD_OUT_W] = m_data_gu[g][u];
    end
  end

  beat_if #(.GROUPS(GROUPS), .UNITS(UNITS), .MEMBERS(MEMBERS)) beat ();

  sample_stage #(.GROUPS(GROUPS), .UNITS(UNITS), .MEMBERS(MEMBERS)) u_sample_stage (
    .clk(clk), .clken(clken), .rst_n(rst_n), .cfg_clear(cfg_clear),
    .s_valid(s_valid), .s_user(s_user), .s_data(s_data_gu), .beat(beat.stage)
  );

  coef_store #(.GROUPS(GROUPS), .MEMBERS(MEMBERS)) u_coef_store (
    .clk(clk), .clken(clken), .rst_n(rst_n), .cfg_clear(cfg_clear),
    .cfg_valid(cfg_valid), .cfg_is_1x1(cfg_is_1x1), .cfg_data(cfg_data_g),
    .beat(beat.store), .a_val(a_val), .b_val(b_val), .d_val(d_val)
  );

  unit_array #(.GROUPS(GROUPS), .UNITS(UNITS), .LRELU_ALPHA(LRELU_ALPHA)) u_unit_array (
    .clk(clk), .clken(clken), .rst_n(rst_n), .beat(beat.unit),
    .a_val(a_val), .b_val(b_val), .d_val(d_val),
    .m_valid(m_valid), .m_user(m_user), .m_data(m_data_gu)
  );

endmodule

`default_nettype wire

// ==== lrelu_monitor.sv ====
`timescale 1ns/10ps
`default_nettype none

module lrelu_monitor #(
  parameter int GROUPS      = 2,
  parameter int UNITS       = 4,
  parameter int MEMBERS     = 2,
  parameter int LRELU_ALPHA = 26
) (
  input  logic                                          clk,
  input  logic                                          clken,
  input  logic                                          rst_n,
  input  logic                                          s_valid,
  input  lrelu_pkg::user_t                              s_user,
  input  logic [GROUPS*UNITS*lrelu_pkg::WORD_IN_W-1:0]  s_data,
  input  logic                                          cfg_clear,
  input  logic                                          cfg_valid,
  input  logic                                          cfg_is_1x1,
  input  logic [GROUPS*lrelu_pkg::COEF_W-1:0]           cfg_data,
  input  logic                                          m_valid,
  input  lrelu_pkg::user_t                              m_user,
  input  logic [GROUPS*UNITS*lrelu_pkg::WORD_OUT_W-1:0] m_data,
  output int                                            errors,
  output int                                            pending
);
  import lrelu_pkg::*;

  localparam int DEPTH = 3 * MEMBERS;
  localparam int DW    = GROUPS * UNITS * WORD_OUT_W;

  int          a_mem [GROUPS][DEPTH];
  int          b_mem [GROUPS][DEPTH];
  int          d_reg [GROUPS];
  int          sel;
  int          waddr;
  int          rd;
  int          err_cnt  = 0;
  int          pend_cnt = 0;
  logic [DW-1:0] exp_data_q [$];
  user_t       exp_user_q [$];

  assign errors  = err_cnt;
  assign pending = pend_cnt;

  // x*a in Q8.8, plus b, optional leaky scaling, plus d, then clamp
  function automatic int expected_sample(input int x, input int a, input int b,
                                         input int d, input bit lrelu);
    longint s;
    s = ((longint'(x) * longint'(a)) >>> COEF_FRAC) + longint'(b);
    if (lrelu && s < 0) s = (s * LRELU_ALPHA) >>> 8;
    s = s + longint'(d);
    if (s > OUT_MAX) s = OUT_MAX;
    if (s < OUT_MIN) s = OUT_MIN;
    return int'(s);
  endfunction

  always @(posedge clk) begin
    logic [DW-1:0] e;
    logic [DW-1:0] got_exp;
    user_t         usr_exp;
    int            last;
    int            k;
    if (!rst_n) begin
      sel = 0;
      waddr = 0;
      rd = 0;
      exp_data_q.delete();
      exp_user_q.delete();
    end else if (clken) begin
      // output held since the previous enabled edge
      if (m_valid) begin
        if (exp_user_q.size() == 0) begin
          err_cnt++;
          $display("error at %0t: output beat arrived with nothing expected", $time);
        end else begin
          got_exp = exp_data_q.pop_front();
          usr_exp = exp_user_q.pop_front();
          if (m_user !== usr_exp) begin
            err_cnt++;
            $display("mismatch at %0t: m_user expected %h got %h", $time, usr_exp, m_user);
          end
          if (m_data !== got_exp) begin
            err_cnt++;
            $display("mismatch at %0t: m_data expected %h got %h", $time, got_exp, m_data);
          end
        end
      end
      if (s_valid) begin
        for (int g = 0; g < GROUPS; g++) begin
          for (int u = 0; u < UNITS; u++) begin
            k = g * UNITS + u;
            e[k*WORD_OUT_W +: WORD_OUT_W] = WORD_OUT_W'(expected_sample(
              $signed(s_data[k*WORD_IN_W +: WORD_IN_W]), a_mem[g][rd], b_mem[g][rd],
              d_reg[g], s_user[I_IS_LRELU]));
          end
        end
        exp_data_q.push_back(e);
        exp_user_q.push_back(s_user);
      end
      last = s_user[I_IS_1X1] ? DEPTH - 1 : MEMBERS - 1;
      if (cfg_clear) rd = 0;
      else if (s_valid) rd = (rd >= last) ? 0 : rd + 1;
      // configuration sequencer model
      last = cfg_is_1x1 ? DEPTH - 1 : MEMBERS - 1;
      if (cfg_clear) begin
        sel = 0;
        waddr = 0;
      end else if (cfg_valid) begin
        for (int g = 0; g < GROUPS; g++) begin
          if (sel == 0) d_reg[g] = $signed(cfg_data[g*COEF_W +: COEF_W]);
          if (sel == 1) a_mem[g][waddr] = $signed(cfg_data[g*COEF_W +: COEF_W]);
          if (sel == 2) b_mem[g][waddr] = $signed(cfg_data[g*COEF_W +: COEF_W]);
        end
        if (sel == 0) begin
          sel = 1;
          waddr = 0;
        end else if (waddr >= last) begin
          sel = (sel == 1) ? 2 : 0;
          waddr = 0;
        end else begin
          waddr = waddr + 1;
        end
      end
    end
    pend_cnt = exp_user_q.size();
  end

endmodule

`default_nettype wire

// ==== lrelu_engine_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module lrelu_engine_chk (
  input logic             clk,
  input logic             clken,
  input logic             rst_n,
  input logic             s_valid,
  input lrelu_pkg::user_t s_user,
  input logic             m_valid,
  input lrelu_pkg::user_t m_user
);
  import lrelu_pkg::*;

  int    fail_count = 0;
  logic  v_hist [PIPE_LATENCY];
  user_t u_hist [PIPE_LATENCY];

  // input history, advanced only on enabled cycles
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < PIPE_LATENCY; i++) v_hist[i] <= 1'b0;
    end else if (clken) begin
      v_hist[0] <= s_valid;
      for (int i = 1; i < PIPE_LATENCY; i++) v_hist[i] <= v_hist[i-1];
    end
  end

  always_ff @(posedge clk) begin
    if (clken) begin
      u_hist[0] <= s_user;
      for (int i = 1; i < PIPE_LATENCY; i++) u_hist[i] <= u_hist[i-1];
    end
  end

  a_reset_low: assert property (@(posedge clk) !rst_n |=> !m_valid)
    else begin
      fail_count = fail_count + 1;
      $error("m_valid high after a reset cycle");
    end

  a_valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
    m_valid == v_hist[PIPE_LATENCY-1])
    else begin
      fail_count = fail_count + 1;
      $error("m_valid does not follow s_valid by the pipeline latency");
    end

  a_user_latency: assert property (@(posedge clk) disable iff (!rst_n)
    m_valid |-> (m_user == u_hist[PIPE_LATENCY-1]))
    else begin
      fail_count = fail_count + 1;
      $error("m_user does not follow s_user by the pipeline latency");
    end

endmodule

bind lrelu_engine lrelu_engine_chk u_chk (
  .clk(clk), .clken(clken), .rst_n(rst_n), .s_valid(s_valid), .s_user(s_user),
  .m_valid(m_valid), .m_user(m_user)
);

`default_nettype wire

// ==== tb_lrelu_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_lrelu_engine;
  import lrelu_pkg::*;

  localparam int GROUPS      = 2;
  localparam int UNITS       = 4;
  localparam int MEMBERS     = 2;
  localparam int LRELU_ALPHA = 26;

  logic clk = 1'b0;
  logic clken;
  logic rst_n;
  logic s_valid;
  user_t s_user;
  logic [GROUPS*UNITS*WORD_IN_W-1:0] s_data;
  logic cfg_clear;
  logic cfg_valid;
  logic cfg_is_1x1;
  logic [GROUPS*COEF_W-1:0] cfg_data;
  logic m_valid;
  user_t m_user;
  logic [GROUPS*UNITS*WORD_OUT_W-1:0] m_data;
  int mon_errors;
  int mon_pending;
  int local_errs = 0;
  int errs_mark = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  always #4 clk = ~clk;

  lrelu_engine #(.GROUPS(GROUPS), .UNITS(UNITS), .MEMBERS(MEMBERS),
                 .LRELU_ALPHA(LRELU_ALPHA)) DUT (
    .clk(clk), .clken(clken), .rst_n(rst_n), .s_valid(s_valid), .s_user(s_user),
    .s_data(s_data), .cfg_clear(cfg_clear), .cfg_valid(cfg_valid),
    .cfg_is_1x1(cfg_is_1x1), .cfg_data(cfg_data),
    .m_valid(m_valid), .m_user(m_user), .m_data(m_data)
  );

  lrelu_monitor #(.GROUPS(GROUPS), .UNITS(UNITS), .MEMBERS(MEMBERS),
                  .LRELU_ALPHA(LRELU_ALPHA)) u_monitor (
    .clk(clk), .clken(clken), .rst_n(rst_n), .s_valid(s_valid), .s_user(s_user),
    .s_data(s_data), .cfg_clear(cfg_clear), .cfg_valid(cfg_valid),
    .cfg_is_1x1(cfg_is_1x1), .cfg_data(cfg_data), .m_valid(m_valid),
    .m_user(m_user), .m_data(m_data), .errors(mon_errors), .pending(mon_pending)
  );

  function automatic int rand_signed(input int span);
    return int'($urandom_range(2 * span, 0)) - span;
  endfunction

  function automatic int total_errors();
    return mon_errors + local_errs + DUT.u_chk.fail_count;
  endfunction

  task automatic start_test();
    errs_mark = total_errors();
  endtask

  task automatic end_test(input string name);
    int n;
    n = total_errors() - errs_mark;
    if (n == 0) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, n);
    end
  endtask

  // word 0 goes to D, the next depth words to A, the rest to B
  task automatic load_coefs(input bit is_1x1, input int words, input int a_span,
                            input int b_span, input int d_span);
    int depth;
    int span;
    depth = is_1x1 ? 3 * MEMBERS : MEMBERS;
    for (int i = 0; i < words; i++) begin
      @(negedge clk);
      cfg_valid  = 1'b1;
      cfg_is_1x1 = is_1x1;
      span = (i == 0) ? d_span : ((i <= depth) ? a_span : b_span);
      for (int g = 0; g < GROUPS; g++) cfg_data[g*COEF_W +: COEF_W] = COEF_W'(rand_signed(span));
    end
    @(negedge clk);
    cfg_valid = 1'b0;
  endtask

  task automatic send_beats(input int n, input bit lrelu, input bit is_1x1, input int span,
                            input bit gaps);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      clken   = gaps ? ($urandom_range(3, 0) != 0) : 1'b1;
      s_valid = 1'b1;
      s_user  = {is_1x1, lrelu};
      for (int k = 0; k < GROUPS * UNITS; k++) begin
        s_data[k*WORD_IN_W +: WORD_IN_W] = WORD_IN_W'(rand_signed(span));
      end
    end
    @(negedge clk);
    s_valid = 1'b0;
    clken   = 1'b1;
  endtask

  task automatic drain();
    int t;
    t = 0;
    while (mon_pending != 0 && t < 100) begin
      @(negedge clk);
      t++;
    end
    if (mon_pending != 0) begin
      local_errs++;
      $display("error at %0t: %0d output beats still missing after the drain timeout",
               $time, mon_pending);
    end
    repeat (2) @(negedge clk);
  endtask

  initial begin
    void'($urandom(32'hac18_6007));
    clken = 1'b1;
    rst_n = 1'b0;
    s_valid = 1'b0;
    s_user = '0;
    s_data = '0;
    cfg_clear = 1'b0;
    cfg_valid = 1'b0;
    cfg_is_1x1 = 1'b0;
    cfg_data = '0;

    start_test();
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      if (i == 4) rst_n = 1'b1;
      if (m_valid !== 1'b0) begin
        local_errs++;
        $display("error at %0t: m_valid not low around reset with no input", $time);
      end
    end
    end_test("reset");

    start_test();
    load_coefs(1'b1, 1 + 6 * MEMBERS, 128, 30, 10);
    send_beats(14, 1'b0, 1'b1, 200, 1'b0);
    drain();
    end_test("1x1 configuration");

    start_test();
    send_beats(12, 1'b1, 1'b1, 300, 1'b0);
    send_beats(12, 1'b0, 1'b1, 300, 1'b0);
    drain();
    end_test("leaky relu");

    // leave the sequencer mid-way, then restart it
    start_test();
    load_coefs(1'b0, 2, 100, 20, 10);
    @(negedge clk);
    cfg_clear = 1'b1;
    @(negedge clk);
    cfg_clear = 1'b0;
    load_coefs(1'b0, 1 + 2 * MEMBERS, 200, 30, 10);
    send_beats(9, 1'b1, 1'b0, 250, 1'b0);
    drain();
    end_test("3x3 after clear");

    start_test();
    load_coefs(1'b0, 1 + 2 * MEMBERS, 8000, 2000, 100);
    send_beats(16, 1'b0, 1'b0, 30000, 1'b0);
    drain();
    end_test("saturation");

    start_test();
    load_coefs(1'b0, 1 + 2 * MEMBERS, 150, 30, 10);
    send_beats(40, 1'b1, 1'b0, 300, 1'b1);
    send_beats(40, 1'b0, 1'b0, 300, 1'b1);
    drain();
    end_test("clock enable gaps");

    $display("tests passed: %0d failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && total_errors() == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    #200000;
    $display("error: simulation watchdog expired");
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
lrelu_pkg.sv
beat_if.sv
sample_stage.sv
coef_store.sv
unit_array.sv
lrelu_engine.sv
lrelu_monitor.sv
lrelu_engine_chk.sv
tb_lrelu_engine.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_lrelu_engine
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then exit 1; fi
	@grep -q ">>> PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
